// ==== hk_defs.svh ====
// Housekeeping widths, register map offsets and DNA sequencer constants
`ifndef HK_DEFS_SVH
`define HK_DEFS_SVH

// Port widths
`define HK_DWL 8   // LED count
`define HK_DWE 8   // Expansion connector pins per side

// Decoded address bits
`define HK_AW 6

// Register byte offsets inside the housekeeping window
`define HK_OFS_ID     6'h00  // Design ID
`define HK_OFS_DNA_LO 6'h04  // DNA bits 31..0
`define HK_OFS_DNA_HI 6'h08  // DNA bits 56..32 and done flag
`define HK_OFS_LOOP   6'h0C  // Digital loop enable
`define HK_OFS_P_OE   6'h10  // P side output enable
`define HK_OFS_N_OE   6'h14  // N side output enable
`define HK_OFS_P_O    6'h18  // P side output value
`define HK_OFS_N_O    6'h1C  // N side output value
`define HK_OFS_P_I    6'h20  // P side input, synchronized
`define HK_OFS_N_I    6'h24  // N side input, synchronized
`define HK_OFS_LED    6'h30  // LED register

// Stand-in DNA for the behavioural cell
`define HK_DNA_SIM 57'h1_0F3C_5A96_D2B7_E4

// DNA sequencer count thresholds
`define HK_DNA_READ_END    10   // Load window ends here
`define HK_DNA_SHIFT_START 18   // Shift window opens past this
`define HK_DNA_DONE_CNT    465  // Readout complete past this

`endif

// ==== hk_bus_pkg.sv ====
// Bus-side types for the housekeeping register interface
package hk_bus_pkg;

  // Full bus address
  // Only the low offset bits reach the decoder
  typedef logic [31:0] addr_t;

  // Bus data word, both directions
  typedef logic [31:0] data_t;

  // Decoded register index, one per mapped offset
  typedef enum logic [3:0] {
    REG_ID,      // Read only
    REG_DNA_LO,  // Read only
    REG_DNA_HI,  // Read only
    REG_LOOP,
    REG_P_OE,
    REG_N_OE,
    REG_P_O,
    REG_N_O,
    REG_P_I,     // Read only
    REG_N_I,     // Read only
    REG_LED,
    REG_NONE     // Unmapped offset, flagged as bus error
  } reg_idx_e;

endpackage

// ==== hk_id_pkg.sv ====
// Identification types for device DNA and the design ID word
package hk_id_pkg;

  // Device DNA as read out of the DNA cell
  // Bit 56 is the first bit shifted out
  typedef logic [56:0] dna_t;

  // Design ID word as seen on the bus
  typedef logic [31:0] id_t;

  // Board type code in ID bits 3..0
  // Release 1 of the board
  localparam logic [3:0] HK_BOARD_TYPE = 4'h1;

endpackage

// ==== hk_dna_cell.sv ====
// Behavioural DNA cell that loads a fixed 57-bit value and shifts it out MSB first
`timescale 1ns/1ns

module hk_dna_cell #(
  parameter hk_id_pkg::dna_t DNA_VALUE = '0  // Value the cell reports
) (
  input  logic dna_clk_i,    // Slow DNA clock from the sequencer
  input  logic dna_read_i,   // Load DNA_VALUE into the shifter
  input  logic dna_shift_i,  // Shift one bit toward the MSB
  output logic dna_dout_o    // Serial data out
);

  import hk_id_pkg::*;

  dna_t shreg;  // Internal shift register

  // Load has priority over shift
  always_ff @(posedge dna_clk_i) begin
    if (dna_read_i) begin
      shreg <= DNA_VALUE;
    end else if (dna_shift_i) begin
      shreg <= {shreg[$bits(dna_t)-2:0], 1'b0};  // Zero fill behind
    end
  end

  assign dna_dout_o = shreg[$bits(dna_t)-1];  // MSB leads

  // The sequencer must keep its load and shift windows apart
  a_read_shift_excl : assert property (
    @(posedge dna_clk_i) !(dna_read_i && dna_shift_i)
  ) else $error("DNA cell saw read and shift together");

endmodule

// ==== hk_dna_reader.sv ====
// DNA readout sequencer that clocks the DNA cell and assembles the DNA value
`timescale 1ns/1ns
`include "hk_defs.svh"

module hk_dna_reader (
  input  logic            bus_clk_i,    // Bus clock
  input  logic            rst_i,        // Sync reset, active high
  // DNA cell side
  input  logic            dna_dout_i,   // Serial bit from the cell
  output logic            dna_clk_o,    // Slow clock, count bit 2
  output logic            dna_read_o,   // Load window
  output logic            dna_shift_o,  // Shift window
  // Result
  output hk_id_pkg::dna_t dna_value_o,  // Assembled DNA
  output logic            dna_done_o    // Readout finished
);

  import hk_id_pkg::*;

  // Sequencer thresholds sized to the counter
  localparam logic [8:0] READ_END    = 9'(`HK_DNA_READ_END);
  localparam logic [8:0] SHIFT_START = 9'(`HK_DNA_SHIFT_START);
  localparam logic [8:0] DONE_CNT    = 9'(`HK_DNA_DONE_CNT);

  logic [8:0] dna_cnt;  // Free-running until done
  logic       sample;   // One sample every 8 counts

  assign sample = (dna_cnt[2:0] == 3'd0) && !dna_done_o;

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus_clk_i) begin
    if (rst_i) begin
      dna_cnt     <= '0;
      dna_clk_o   <= 1'b0;
      dna_read_o  <= 1'b0;
      dna_shift_o <= 1'b0;
      dna_value_o <= '0;
      dna_done_o  <= 1'b0;
    end else begin
      if (!dna_done_o) begin
        dna_cnt <= dna_cnt + 9'd1;  // Freezes once done
      end

      // Cell controls, registered so they move with the clock
      dna_clk_o   <= dna_cnt[2];
      dna_read_o  <= (dna_cnt < READ_END);
      dna_shift_o <= (dna_cnt > SHIFT_START);

      // Early samples fall off the top, the last 57 stay
      if (sample) begin
        dna_value_o <= {dna_value_o[$bits(dna_t)-2:0], dna_dout_i};
      end

      if (dna_cnt > DONE_CNT) begin
        dna_done_o <= 1'b1;  // Sticky until reset
      end
    end
  end

endmodule

// ==== hk_input_sync.sv ====
// Two-flop synchronizer bringing expansion connector inputs into the bus clock
`timescale 1ns/1ns
`include "hk_defs.svh"

module hk_input_sync (
  input  logic               bus_clk_i,  // Bus clock
  input  logic               rst_i,      // Sync reset, active high
  input  logic [`HK_DWE-1:0] async_i,    // Raw pin levels
  output logic [`HK_DWE-1:0] sync_o      // Synchronized, 2 cycles late
);

  // First stage may go metastable
  logic [`HK_DWE-1:0] meta;

  ////////////////////////////////////////////////////////////
  // Synchronizer chain
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus_clk_i) begin
    if (rst_i) begin
      meta   <= '0;
      sync_o <= '0;
    end else begin
      meta   <= async_i;  // Capture
      sync_o <= meta;     // Settle
    end
  end

  // Each pin is synchronized on its own
  // Pins that change together may land a cycle apart

endmodule

// ==== hk_bus_decode.sv ====
// Bus pipeline stage 1, registers the request and decodes the register index
`timescale 1ns/1ns
`include "hk_defs.svh"

module hk_bus_decode (
  input  logic                 bus_clk_i,    // Bus clock
  input  logic                 rst_i,        // Sync reset, active high
  // Bus request
  input  hk_bus_pkg::addr_t    bus_addr_i,   // Byte address
  input  hk_bus_pkg::data_t    bus_wdata_i,  // Write data
  input  logic                 bus_wen_i,    // Write strobe, one cycle
  input  logic                 bus_ren_i,    // Read strobe, one cycle
  // Registered request to stage 2
  output logic                 dec_wen_o,
  output logic                 dec_ren_o,
  output hk_bus_pkg::reg_idx_e dec_idx_o,
  output hk_bus_pkg::data_t    dec_wdata_o
);

  import hk_bus_pkg::*;

  logic [`HK_AW-1:0] ofs;  // Offset within the block
  reg_idx_e          idx;  // Decoded this cycle

  assign ofs = bus_addr_i[`HK_AW-1:0];  // Upper bits select the block elsewhere

  // Offset to register index
  always_comb begin
    case (ofs)
      `HK_OFS_ID:     idx = REG_ID;
      `HK_OFS_DNA_LO: idx = REG_DNA_LO;
      `HK_OFS_DNA_HI: idx = REG_DNA_HI;
      `HK_OFS_LOOP:   idx = REG_LOOP;
      `HK_OFS_P_OE:   idx = REG_P_OE;
      `HK_OFS_N_OE:   idx = REG_N_OE;
      `HK_OFS_P_O:    idx = REG_P_O;
      `HK_OFS_N_O:    idx = REG_N_O;
      `HK_OFS_P_I:    idx = REG_P_I;
      `HK_OFS_N_I:    idx = REG_N_I;
      `HK_OFS_LED:    idx = REG_LED;
      default:        idx = REG_NONE;  // Holes in the map
    endcase
  end

  // Strobes and index carry reset state, write data does not
  always_ff @(posedge bus_clk_i) begin
    if (rst_i) begin
      dec_wen_o <= 1'b0;
      dec_ren_o <= 1'b0;
      dec_idx_o <= REG_NONE;
    end else begin
      dec_wen_o <= bus_wen_i;
      dec_ren_o <= bus_ren_i;
      dec_idx_o <= idx;
    end
  end

  always_ff @(posedge bus_clk_i) begin
    dec_wdata_o <= bus_wdata_i;
  end

  // Master issues one kind of access per cycle
  a_one_strobe : assert property (
    @(posedge bus_clk_i) disable iff (rst_i) !(bus_wen_i && bus_ren_i)
  ) else $error("Write and read strobe in the same cycle");

endmodule

// ==== hk_regs.sv ====
// Bus pipeline stage 2 with control registers, read multiplexer, ack and err
`timescale 1ns/1ns
`include "hk_defs.svh"

module hk_regs (
  input  logic                 bus_clk_i,       // Bus clock
  input  logic                 rst_i,           // Sync reset, active high
  // Request from stage 1
  input  logic                 dec_wen_i,
  input  logic                 dec_ren_i,
  input  hk_bus_pkg::reg_idx_e dec_idx_i,
  input  hk_bus_pkg::data_t    dec_wdata_i,
  // Identification
  input  hk_id_pkg::dna_t      dna_value_i,     // From the sequencer
  input  logic                 dna_done_i,      // DNA valid
  // Synchronized expansion inputs
  input  logic [`HK_DWE-1:0]   exp_p_sync_i,
  input  logic [`HK_DWE-1:0]   exp_n_sync_i,
  // Control outputs
  output logic [`HK_DWL-1:0]   led_o,
  output logic                 digital_loop_o,  // Stored only
  output logic [`HK_DWE-1:0]   exp_p_o,
  output logic [`HK_DWE-1:0]   exp_p_oe_o,
  output logic [`HK_DWE-1:0]   exp_n_o,
  output logic [`HK_DWE-1:0]   exp_n_oe_o,
  // Bus response
  output logic                 bus_ack_o,       // One pulse per access
  output logic                 bus_err_o,       // Unmapped offset
  output hk_bus_pkg::data_t    bus_rdata_o      // Valid with ack
);

  import hk_bus_pkg::*;
  import hk_id_pkg::*;

  logic  dec_req;   // Any access in stage 2
  id_t   id_value;  // Fixed design ID
  data_t rd_mux;    // Read data before the output flop

  assign dec_req  = dec_wen_i | dec_ren_i;
  assign id_value = {28'h0, HK_BOARD_TYPE};  // Upper bits reserved

  ////////////////////////////////////////////////////////////
  // Writable registers
  ////////////////////////////////////////////////////////////

  // Read-only and unmapped indexes drop the write
  always_ff @(posedge bus_clk_i) begin
    if (rst_i) begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
      exp_p_o        <= '0;
      exp_p_oe_o     <= '0;
      exp_n_o        <= '0;
      exp_n_oe_o     <= '0;
    end else if (dec_wen_i) begin
      case (dec_idx_i)
        REG_LOOP: digital_loop_o <= dec_wdata_i[0];
        REG_P_OE: exp_p_oe_o     <= dec_wdata_i[`HK_DWE-1:0];
        REG_N_OE: exp_n_oe_o     <= dec_wdata_i[`HK_DWE-1:0];
        REG_P_O:  exp_p_o        <= dec_wdata_i[`HK_DWE-1:0];
        REG_N_O:  exp_n_o        <= dec_wdata_i[`HK_DWE-1:0];
        REG_LED:  led_o          <= dec_wdata_i[`HK_DWL-1:0];
        default:  ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Read path and response
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (dec_idx_i)
      REG_ID:     rd_mux = id_value;
      REG_DNA_LO: rd_mux = dna_value_i[31:0];
      REG_DNA_HI: rd_mux = {dna_done_i, 6'b0, dna_value_i[56:32]};  // Done in bit 31
      REG_LOOP:   rd_mux = data_t'(digital_loop_o);
      REG_P_OE:   rd_mux = data_t'(exp_p_oe_o);
      REG_N_OE:   rd_mux = data_t'(exp_n_oe_o);
      REG_P_O:    rd_mux = data_t'(exp_p_o);
      REG_N_O:    rd_mux = data_t'(exp_n_o);
      REG_P_I:    rd_mux = data_t'(exp_p_sync_i);
      REG_N_I:    rd_mux = data_t'(exp_n_sync_i);
      REG_LED:    rd_mux = data_t'(led_o);
      default:    rd_mux = '0;  // REG_NONE reads zero
    endcase
  end

  always_ff @(posedge bus_clk_i) begin
    if (rst_i) begin
      bus_ack_o <= 1'b0;
      bus_err_o <= 1'b0;
    end else begin
      bus_ack_o <= dec_req;
      bus_err_o <= dec_req && (dec_idx_i == REG_NONE);
    end
  end

  always_ff @(posedge bus_clk_i) begin
    bus_rdata_o <= rd_mux;  // Follows the index every cycle
  end

  // DNA words must hold still once the sequencer reports done
  a_dna_stable : assert property (
    @(posedge bus_clk_i) disable iff (rst_i)
      dna_done_i && $past(dna_done_i) |-> $stable(dna_value_i)
  ) else $error("DNA value changed after done");

endmodule

// ==== hk_top.sv ====
// Housekeeping top level joining the DNA readout, input synchronizers and bus pipeline
`timescale 1ns/1ns
`include "hk_defs.svh"

module hk_top #(
  parameter hk_id_pkg::dna_t DNA_VALUE = `HK_DNA_SIM  // Reported by the DNA cell
) (
  input  logic               bus_clk_i,       // Bus clock
  input  logic               rst_i,           // Sync reset, active high
  // System bus
  input  hk_bus_pkg::addr_t  bus_addr_i,
  input  hk_bus_pkg::data_t  bus_wdata_i,
  input  logic               bus_wen_i,
  input  logic               bus_ren_i,
  output logic               bus_ack_o,
  output logic               bus_err_o,
  output hk_bus_pkg::data_t  bus_rdata_o,
  // LEDs and global config
  output logic [`HK_DWL-1:0] led_o,
  output logic               digital_loop_o,
  // Expansion connector
  input  logic [`HK_DWE-1:0] exp_p_i,
  input  logic [`HK_DWE-1:0] exp_n_i,
  output logic [`HK_DWE-1:0] exp_p_o,
  output logic [`HK_DWE-1:0] exp_p_oe_o,
  output logic [`HK_DWE-1:0] exp_n_o,
  output logic [`HK_DWE-1:0] exp_n_oe_o
);

  import hk_bus_pkg::*;
  import hk_id_pkg::*;

  ////////////////////////////////////////////////////////////
  // Device DNA
  ////////////////////////////////////////////////////////////

  logic dna_clk, dna_read, dna_shift, dna_dout;
  dna_t dna_value;
  logic dna_done;

  hk_dna_reader u_dna_reader (
    .bus_clk_i   (bus_clk_i),
    .rst_i       (rst_i),
    .dna_dout_i  (dna_dout),
    .dna_clk_o   (dna_clk),
    .dna_read_o  (dna_read),
    .dna_shift_o (dna_shift),
    .dna_value_o (dna_value),
    .dna_done_o  (dna_done)
  );

  hk_dna_cell #(.DNA_VALUE(DNA_VALUE)) u_dna_cell (
    .dna_clk_i   (dna_clk),
    .dna_read_i  (dna_read),
    .dna_shift_i (dna_shift),
    .dna_dout_o  (dna_dout)
  );

  // Expansion inputs, one synchronizer per side
  logic [`HK_DWE-1:0] exp_p_sync, exp_n_sync;

  hk_input_sync u_sync_p (.bus_clk_i(bus_clk_i), .rst_i(rst_i), .async_i(exp_p_i), .sync_o(exp_p_sync));
  hk_input_sync u_sync_n (.bus_clk_i(bus_clk_i), .rst_i(rst_i), .async_i(exp_n_i), .sync_o(exp_n_sync));

  // Two-stage bus pipeline
  logic     dec_wen, dec_ren;
  reg_idx_e dec_idx;
  data_t    dec_wdata;

  hk_bus_decode u_bus_decode (
    .bus_clk_i   (bus_clk_i),
    .rst_i       (rst_i),
    .bus_addr_i  (bus_addr_i),
    .bus_wdata_i (bus_wdata_i),
    .bus_wen_i   (bus_wen_i),
    .bus_ren_i   (bus_ren_i),
    .dec_wen_o   (dec_wen),
    .dec_ren_o   (dec_ren),
    .dec_idx_o   (dec_idx),
    .dec_wdata_o (dec_wdata)
  );

  hk_regs u_regs (
    .bus_clk_i      (bus_clk_i),
    .rst_i          (rst_i),
    .dec_wen_i      (dec_wen),
    .dec_ren_i      (dec_ren),
    .dec_idx_i      (dec_idx),
    .dec_wdata_i    (dec_wdata),
    .dna_value_i    (dna_value),
    .dna_done_i     (dna_done),
    .exp_p_sync_i   (exp_p_sync),
    .exp_n_sync_i   (exp_n_sync),
    .led_o          (led_o),
    .digital_loop_o (digital_loop_o),
    .exp_p_o        (exp_p_o),
    .exp_p_oe_o     (exp_p_oe_o),
    .exp_n_o        (exp_n_o),
    .exp_n_oe_o     (exp_n_oe_o),
    .bus_ack_o      (bus_ack_o),
    .bus_err_o      (bus_err_o),
    .bus_rdata_o    (bus_rdata_o)
  );

endmodule

// ==== tb_hk_top.sv ====
// Housekeeping testbench that replays bus operations from a stimulus file and checks every ack
`timescale 1ns/1ns

module tb_hk_top;

  // Expected response of one outstanding bus access
  typedef struct packed {
    logic        wr;
    logic [31:0] addr;
    logic [31:0] exp;   // Pin value for writes, rdata for reads
    logic        err;
    logic [31:0] cyc;   // Cycle of the strobe
    logic [31:0] num;   // Test number
  } access_t;

  logic        bus_clk;
  logic        rst;
  logic [31:0] bus_addr, bus_wdata, bus_rdata;
  logic        bus_wen, bus_ren, bus_ack, bus_err;
  logic [7:0]  led, exp_p_in, exp_n_in, exp_p, exp_p_oe, exp_n, exp_n_oe;
  logic        digital_loop;

  access_t     pend_q[$];     // In issue order
  int          cyc = 0;       // Rising edges so far
  int          line_cnt = 0;  // Sizes the watchdog
  int          err_cnt = 0;
  int          n_pass = 0;
  int          n_fail = 0;
  logic        polling = 1'b0;  // DNA poll owns the bus

  initial bus_clk = 1'b0;
  always #50 bus_clk = ~bus_clk;  // 100 ns period

  always @(posedge bus_clk) cyc <= cyc + 1;

  hk_top dut0 (
    .bus_clk_i      (bus_clk),
    .rst_i          (rst),
    .bus_addr_i     (bus_addr),
    .bus_wdata_i    (bus_wdata),
    .bus_wen_i      (bus_wen),
    .bus_ren_i      (bus_ren),
    .bus_ack_o      (bus_ack),
    .bus_err_o      (bus_err),
    .bus_rdata_o    (bus_rdata),
    .led_o          (led),
    .digital_loop_o (digital_loop),
    .exp_p_i        (exp_p_in),
    .exp_n_i        (exp_n_in),
    .exp_p_o        (exp_p),
    .exp_p_oe_o     (exp_p_oe),
    .exp_n_o        (exp_n),
    .exp_n_oe_o     (exp_n_oe)
  );

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      err_cnt++;
    end
  endtask

  // Register pins behind each writable offset
  task automatic check_outputs(input logic [31:0] addr, input logic [31:0] exp);
    case (addr[5:0])
      6'h0C:   compare_value("digital_loop_o", {31'h0, digital_loop}, exp);
      6'h10:   compare_value("exp_p_oe_o", {24'h0, exp_p_oe}, exp);
      6'h14:   compare_value("exp_n_oe_o", {24'h0, exp_n_oe}, exp);
      6'h18:   compare_value("exp_p_o", {24'h0, exp_p}, exp);
      6'h1C:   compare_value("exp_n_o", {24'h0, exp_n}, exp);
      6'h30:   compare_value("led_o", {24'h0, led}, exp);
      default: ;  // Read-only or unmapped offsets have no pin
    endcase
  endtask

  // Each ack matches the queue front two cycles after its strobe
  always @(negedge bus_clk) begin : ack_monitor
    access_t acc;
    int      errs_before;
    if (!rst && !polling) begin
      if (bus_ack) begin
        if (pend_q.size() == 0) begin
          $display("Ack arrived with no access outstanding");
          err_cnt++;
          n_fail++;
        end else begin
          acc = pend_q.pop_front();
          errs_before = err_cnt;
          compare_value("ack latency", cyc - acc.cyc, 32'd2);
          compare_value("bus_err_o", {31'h0, bus_err}, {31'h0, acc.err});
          if (acc.wr) check_outputs(acc.addr, acc.exp);
          else compare_value("bus_rdata_o", bus_rdata, acc.exp);
          if (err_cnt == errs_before) n_pass++;
          else n_fail++;
          $display("[%s] test %0d: %s 0x%02h", (err_cnt == errs_before) ? "PASS" : "FAIL",
                   acc.num, acc.wr ? "W" : "R", acc.addr[7:0]);
        end
      end else if (pend_q.size() != 0 && cyc - pend_q[0].cyc >= 2) begin
        acc = pend_q.pop_front();
        $display("Test %0d got no ack two cycles after its strobe", acc.num);
        err_cnt++;
        n_fail++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic issue_access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                              input logic [31:0] exp, input logic err, input int num);
    access_t acc;
    acc.wr   = wr;
    acc.addr = addr;
    acc.exp  = exp;
    acc.err  = err;
    acc.cyc  = cyc;
    acc.num  = num;
    bus_addr  = addr;
    bus_wdata = data;
    bus_wen   = wr;
    bus_ren   = !wr;
    pend_q.push_back(acc);
    @(negedge bus_clk);
    bus_wen = 1'b0;  // Next access may strobe again right here
    bus_ren = 1'b0;
  endtask

  task automatic drain_pipeline();
    int waited;
    waited = 0;
    while (pend_q.size() != 0 && waited < 8) begin
      @(negedge bus_clk);
      waited++;
    end
    if (pend_q.size() != 0) begin
      $display("Bus pipeline did not drain, %0d accesses never acked", pend_q.size());
      err_cnt++;
      n_fail++;
      pend_q.delete();
    end
  endtask

  task automatic drive_pins(input logic [7:0] p, input logic [7:0] n, input int num);
    drain_pipeline();
    exp_p_in = p;
    exp_n_in = n;
    repeat (3) @(negedge bus_clk);  // Past the synchronizer latency
    $display("[INFO] test %0d: pins driven p=0x%02h n=0x%02h", num, p, n);
  endtask

  // Poll the DNA high word until its done bit shows
  task automatic wait_dna(input logic [31:0] addr, input int num);
    int   polls;
    int   waited;
    logic done;
    drain_pipeline();
    polling = 1'b1;
    done = 1'b0;
    polls = 0;
    // Readout needs about 470 cycles, each poll takes two
    while (!done && polls < 300) begin
      bus_addr = addr;
      bus_ren  = 1'b1;
      @(negedge bus_clk);
      bus_ren = 1'b0;
      waited = 0;
      while (!bus_ack && waited < 4) begin
        @(negedge bus_clk);
        waited++;
      end
      if (bus_ack) done = bus_rdata[31];
      polls++;
    end
    @(negedge bus_clk);  // Let the last ack go before the monitor resumes
    polling = 1'b0;
    if (done) begin
      n_pass++;
      $display("[PASS] test %0d: DNA done after %0d polls", num, polls);
    end else begin
      $display("DNA readout never reported done after %0d polls", polls);
      err_cnt++;
      n_fail++;
    end
  endtask

  task automatic run_stimulus(input int fd);
    logic [8*16-1:0]  tok;
    logic [8*128-1:0] rest;
    logic [31:0]      f_addr, f_data, f_exp, f_err;
    int               n;
    int               num;
    num = 0;
    while (1) begin
      n = $fscanf(fd, "%s", tok);
      if (n != 1) break;
      if (tok[7:0] == "#") begin
        n = $fgets(rest, fd);  // Comment line
      end else begin
        n = $fscanf(fd, "%h %h %h %h", f_addr, f_data, f_exp, f_err);
        num++;
        case (tok[7:0])
          "W", "R": issue_access(tok[7:0] == "W", f_addr, f_data, f_exp, f_err[0], num);
          "P":      drive_pins(f_addr[7:0], f_data[7:0], num);
          "D":      wait_dna(f_addr, num);
          default: begin
            $display("Unknown operation on stimulus line %0d", num);
            err_cnt++;
            n_fail++;
          end
        endcase
      end
    end
    drain_pipeline();
  endtask

  initial begin : run
    int               fd;
    logic [8*128-1:0] rest;
    rst       = 1'b1;
    bus_addr  = '0;
    bus_wdata = '0;
    bus_wen   = 1'b0;
    bus_ren   = 1'b0;
    exp_p_in  = '0;
    exp_n_in  = '0;
    repeat (4) @(posedge bus_clk);  // Reset for 4 cycles
    @(negedge bus_clk);
    rst = 1'b0;
    fd = $fopen("hk_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file hk_stimulus.txt");
      err_cnt++;
    end else begin
      while ($fgets(rest, fd) != 0) line_cnt++;
      $fclose(fd);
      fd = $fopen("hk_stimulus.txt", "r");
      run_stimulus(fd);
      $fclose(fd);
    end
    $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0 && err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Limit grows with the stimulus length
  initial begin : watchdog
    wait (line_cnt != 0);
    repeat (line_cnt * 10 + 600) @(posedge bus_clk);
    $display("Timeout: the run went past its cycle limit without finishing");
    $display("Test failed");
    $finish;
  end

endmodule

// ==== hk_stimulus.txt ====
# op addr data expect err, all hex; W expect is the pin value, R expect is rdata
# P drives exp_p_i from addr and exp_n_i from data; D polls addr until DNA done
R 00 00000000 00000001 0
W 30 000000A5 000000A5 0
R 30 00000000 000000A5 0
W 0C FFFFFFFF 00000001 0
R 0C 00000000 00000001 0
W 10 12345678 00000078 0
W 14 0000C3F0 000000F0 0
W 18 FFFFFF81 00000081 0
W 1C 0000005A 0000005A 0
R 10 00000000 00000078 0
R 14 00000000 000000F0 0
R 18 00000000 00000081 0
R 1C 00000000 0000005A 0
R 2C 00000000 00000000 1
W 3C 12345678 00000000 1
R 3C 00000000 00000000 1
W 00 DEADBEEF 00000000 0
R 00 00000000 00000001 0
P 3C 000000C5 00000000 0
R 20 00000000 0000003C 0
R 24 00000000 000000C5 0
D 08 00000000 00000000 0
R 04 00000000 96D2B7E4 0
R 08 00000000 810F3C5A 0

// ==== hk_top.f ====
+incdir+.
hk_bus_pkg.sv
hk_id_pkg.sv
hk_dna_cell.sv
hk_dna_reader.sv
hk_input_sync.sv
hk_bus_decode.sv
hk_regs.sv
hk_top.sv
tb_hk_top.sv

// ==== Bender.yml ====
package:
  name: hk_top

sources:
  - include_dirs:
      - .
    files:
      - hk_bus_pkg.sv
      - hk_id_pkg.sv
      - hk_dna_cell.sv
      - hk_dna_reader.sv
      - hk_input_sync.sv
      - hk_bus_decode.sv
      - hk_regs.sv
      - hk_top.sv
  - target: test
    files:
      - tb_hk_top.sv
